// ==== build.f ====
logic/host_rd_pkg.sv
logic/rd_burst_splitter.sv
logic/rob_bank.sv
logic/rob_drain.sv
logic/host_rd_top.sv
testbench/host_mem_model.sv
testbench/host_rd_tb.sv

// ==== logic/host_rd_pkg.sv ====
/* Shared geometry for the host read path. N_BANKS and BANK_SLOTS must be powers of two,
   and MAX_PKT_LINES in the top level must not exceed ROB_LINES or the pkt_len_t range */
`default_nettype none

package host_rd_pkg;

    // Line and bus widths
    localparam int DATA_WIDTH      = 64;
    localparam int ADDR_WIDTH      = 32;
    localparam int BURST_CNT_WIDTH = 7;

    // Reorder buffer geometry, banks interleaved on the low index bits
    localparam int N_BANKS       = 4;
    localparam int BANK_SLOTS    = 4;
    localparam int ROB_LINES     = N_BANKS * BANK_SLOTS;
    localparam int ROB_IDX_WIDTH = $clog2(ROB_LINES);
    localparam int BANK_WIDTH    = $clog2(N_BANKS);
    localparam int SLOT_WIDTH    = $clog2(BANK_SLOTS);

    // Bank in the low bits, so consecutive lines go to consecutive banks
    typedef struct packed {
        logic [SLOT_WIDTH-1:0] slot;
        logic [BANK_WIDTH-1:0] bank;
    } rob_loc_t;

    // The same ROB index, seen flat or split into bank and slot
    typedef union packed {
        logic [ROB_IDX_WIDTH-1:0] idx;
        rob_loc_t                 loc;
    } rob_tag_t;

    // Packet length in lines, up to 8
    typedef logic [3:0] pkt_len_t;

endpackage

`default_nettype wire

// ==== logic/host_rd_top.sv ====
/* Host memory read path with an in-order ROB. The host port has no back-pressure,
   and completions may arrive in any order, one line per strobe */
`default_nettype none

module host_rd_top
#(
    parameter int MAX_PKT_LINES = 4,
    parameter int PAGE_LINES    = 512
)
(
    input  wire logic                                     afu_clk,
    input  wire logic                                     reset,

    // AFU read port, line addresses
    input  wire logic                                     rd_read,
    input  wire logic [host_rd_pkg::ADDR_WIDTH-1:0]       rd_address,
    input  wire logic [host_rd_pkg::BURST_CNT_WIDTH-1:0]  rd_burstcount,
    output logic                                          rd_waitrequest,
    output logic [host_rd_pkg::DATA_WIDTH-1:0]            rd_readdata,
    output logic                                          rd_readdatavalid,

    // Host request packets
    output logic                                          req_valid,
    output logic [host_rd_pkg::ADDR_WIDTH-1:0]            req_address,
    output host_rd_pkg::pkt_len_t                         req_len,
    output host_rd_pkg::rob_tag_t                         req_tag,

    // Host completions, one line each
    input  wire logic                                     cpl_valid,
    input  wire host_rd_pkg::rob_tag_t                    cpl_tag,
    input  wire logic [host_rd_pkg::DATA_WIDTH-1:0]       cpl_data
);

    logic                                                  line_retired;
    logic [host_rd_pkg::N_BANKS-1:0][host_rd_pkg::BANK_SLOTS-1:0] slot_valid;
    logic [host_rd_pkg::N_BANKS-1:0][host_rd_pkg::BANK_SLOTS-1:0]
          [host_rd_pkg::DATA_WIDTH-1:0]                    slot_data;
    logic [host_rd_pkg::N_BANKS-1:0]                       clear_valid;
    logic [host_rd_pkg::SLOT_WIDTH-1:0]                    clear_slot;

    // ====================
    // Request side
    // ====================

    rd_burst_splitter
    #(
        .MAX_PKT_LINES (MAX_PKT_LINES),
        .PAGE_LINES    (PAGE_LINES)
    )
    u_splitter
    (
        .afu_clk, .reset,
        .rd_read, .rd_address, .rd_burstcount, .rd_waitrequest,
        .line_retired,
        .req_valid, .req_address, .req_len, .req_tag
    );

    // ====================
    // Reorder buffer
    // ====================

    // Every bank sees every completion and keeps only its own
    for (genvar b = 0; b < host_rd_pkg::N_BANKS; b++)
    begin : g_bank
        rob_bank #(.BANK_ID(b)) u_bank
        (
            .afu_clk, .reset,
            .cpl_valid, .cpl_tag, .cpl_data,
            .clear_valid (clear_valid[b]),
            .clear_slot,
            .slot_valid  (slot_valid[b]),
            .slot_data   (slot_data[b])
        );
    end

    rob_drain u_drain
    (
        .afu_clk, .reset,
        .slot_valid, .slot_data,
        .clear_valid, .clear_slot,
        .rd_readdata, .rd_readdatavalid,
        .line_retired
    );

endmodule

`default_nettype wire

// ==== logic/rd_burst_splitter.sv ====
/* Burst counts must be at least 1 and PAGE_LINES a power of two.
   Only one burst is in flight in the splitter; rd_waitrequest covers the rest */
`default_nettype none

module rd_burst_splitter
#(
    parameter int MAX_PKT_LINES = 4,
    parameter int PAGE_LINES    = 512
)
(
    input  wire logic                                     afu_clk,
    input  wire logic                                     reset,

    input  wire logic                                     rd_read,
    input  wire logic [host_rd_pkg::ADDR_WIDTH-1:0]       rd_address,
    input  wire logic [host_rd_pkg::BURST_CNT_WIDTH-1:0]  rd_burstcount,
    output logic                                          rd_waitrequest,

    input  wire logic                                     line_retired,

    output logic                                          req_valid,
    output logic [host_rd_pkg::ADDR_WIDTH-1:0]            req_address,
    output host_rd_pkg::pkt_len_t                         req_len,
    output host_rd_pkg::rob_tag_t                         req_tag
);

    localparam int AW       = host_rd_pkg::ADDR_WIDTH;
    localparam int CREDIT_W = $clog2(host_rd_pkg::ROB_LINES + 1);

    // Burst being cut, held from acceptance until the last packet leaves
    logic                                      busy;
    logic [AW-1:0]                             cur_addr;
    logic [host_rd_pkg::BURST_CNT_WIDTH-1:0]   remain;
    host_rd_pkg::rob_tag_t                     tail;
    logic [CREDIT_W-1:0]                       credits;

    logic [AW-1:0]                             page_left;
    logic [AW-1:0]                             len_full;
    host_rd_pkg::pkt_len_t                     pkt_len;
    logic                                      issue;

    // ====================
    // Next packet length
    // ====================

    always_comb
    begin
        // Lines from the current address to the end of its page
        page_left = AW'(PAGE_LINES) - (cur_addr & AW'(PAGE_LINES - 1));
        len_full = AW'(remain);
        if (len_full > AW'(MAX_PKT_LINES))
            len_full = AW'(MAX_PKT_LINES);
        if (len_full > page_left)
            len_full = page_left;
        pkt_len = host_rd_pkg::pkt_len_t'(len_full);
    end

    // A packet leaves only when the ROB has room for all of its lines
    assign issue = busy && (credits >= CREDIT_W'(pkt_len));

    assign rd_waitrequest = busy;

    // ====================
    // Control state
    // ====================

    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            tail.idx  <= '0;
            credits   <= CREDIT_W'(host_rd_pkg::ROB_LINES);
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= issue;
            // Spent credits go out with the packet; the drain returns one per line
            credits <= credits - (issue ? CREDIT_W'(pkt_len) : CREDIT_W'(0))
                               + CREDIT_W'(line_retired);
            if (!busy && rd_read)
                busy <= 1'b1;
            else if (issue && (AW'(remain) == AW'(pkt_len)))
                busy <= 1'b0;
            if (issue)
                tail.idx <= tail.idx + host_rd_pkg::ROB_IDX_WIDTH'(pkt_len);
        end
    end

    // Payload registers follow the control state and need no reset
    always_ff @(posedge afu_clk)
    begin
        if (!busy && rd_read)
        begin
            cur_addr <= rd_address;
            remain   <= rd_burstcount;
        end
        else if (issue)
        begin
            cur_addr <= cur_addr + AW'(pkt_len);
            remain   <= remain - host_rd_pkg::BURST_CNT_WIDTH'(pkt_len);
        end
        if (issue)
        begin
            req_address <= cur_addr;
            req_len     <= pkt_len;
            req_tag     <= tail;
        end
    end

    // A request packet must end at or before the page boundary
    assert property (@(posedge afu_clk) disable iff (reset)
        req_valid |-> ((req_address & AW'(PAGE_LINES - 1)) + AW'(req_len)) <= AW'(PAGE_LINES));

    // Retired lines can never return more credits than were handed out
    assert property (@(posedge afu_clk) disable iff (reset)
        credits <= CREDIT_W'(host_rd_pkg::ROB_LINES));

endmodule

`default_nettype wire

// ==== logic/rob_bank.sv ====
/* One interleaved ROB bank. The host must never complete a tag twice
   before it is drained */
`default_nettype none

module rob_bank
#(
    parameter int BANK_ID = 0
)
(
    input  wire logic                                  afu_clk,
    input  wire logic                                  reset,

    // Completion broadcast, shared by all banks
    input  wire logic                                  cpl_valid,
    input  wire host_rd_pkg::rob_tag_t                 cpl_tag,
    input  wire logic [host_rd_pkg::DATA_WIDTH-1:0]    cpl_data,

    // Drain side
    input  wire logic                                  clear_valid,
    input  wire logic [host_rd_pkg::SLOT_WIDTH-1:0]    clear_slot,
    output logic [host_rd_pkg::BANK_SLOTS-1:0]         slot_valid,
    output logic [host_rd_pkg::BANK_SLOTS-1:0][host_rd_pkg::DATA_WIDTH-1:0] slot_data
);

    localparam int BW = host_rd_pkg::BANK_WIDTH;

    logic wr_hit;

    // Only completions whose bank field names this bank are stored here
    assign wr_hit = cpl_valid && (cpl_tag.loc.bank == BW'(BANK_ID));

    // ====================
    // Slot storage
    // ====================

    always_ff @(posedge afu_clk)
    begin
        if (wr_hit)
            slot_data[cpl_tag.loc.slot] <= cpl_data;
    end

    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            slot_valid <= '0;
        end
        else
        begin
            // The drained slot and the written slot never coincide
            if (clear_valid)
                slot_valid[clear_slot] <= 1'b0;
            if (wr_hit)
                slot_valid[cpl_tag.loc.slot] <= 1'b1;
        end
    end

    // Credits in the splitter keep a tag from being reused before it drains
    assert property (@(posedge afu_clk) disable iff (reset)
        wr_hit |-> !slot_valid[cpl_tag.loc.slot]);

endmodule

`default_nettype wire

// ==== logic/rob_drain.sv ====
/* Returns lines strictly in ROB index order, at most one per cycle.
   The head index must start where the splitter's tail starts, at zero */
`default_nettype none

module rob_drain
(
    input  wire logic                                  afu_clk,
    input  wire logic                                  reset,

    // Valid bits and data from every bank
    input  wire logic [host_rd_pkg::N_BANKS-1:0][host_rd_pkg::BANK_SLOTS-1:0] slot_valid,
    input  wire logic [host_rd_pkg::N_BANKS-1:0][host_rd_pkg::BANK_SLOTS-1:0]
                      [host_rd_pkg::DATA_WIDTH-1:0]   slot_data,

    // One clear strobe per bank, with a shared slot number
    output logic [host_rd_pkg::N_BANKS-1:0]            clear_valid,
    output logic [host_rd_pkg::SLOT_WIDTH-1:0]         clear_slot,

    output logic [host_rd_pkg::DATA_WIDTH-1:0]         rd_readdata,
    output logic                                       rd_readdatavalid,

    // One pulse per line handed back, returned as a credit
    output logic                                       line_retired
);

    // Oldest line not yet returned to the AFU
    host_rd_pkg::rob_tag_t head;
    logic                  head_ready;

    // ====================
    // Head lookup
    // ====================

    // The union splits the flat head index into bank and slot
    assign head_ready = slot_valid[head.loc.bank][head.loc.slot];

    assign clear_slot   = head.loc.slot;
    assign line_retired = head_ready;

    always_comb
    begin
        clear_valid = '0;
        clear_valid[head.loc.bank] = head_ready;
    end

    // ====================
    // Return to the AFU
    // ====================

    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            head.idx         <= '0;
            rd_readdatavalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid <= head_ready;
            // Wraps with the ROB size, matching the splitter's tail
            if (head_ready)
                head.idx <= head.idx + 1'b1;
        end
    end

    // Read data is only meaningful under rd_readdatavalid
    always_ff @(posedge afu_clk)
    begin
        if (head_ready)
            rd_readdata <= slot_data[head.loc.bank][head.loc.slot];
    end

    // Banks come out of reset empty, so nothing returns or retires right after
    assert property (@(posedge afu_clk)
        reset |=> !rd_readdatavalid && !line_retired);

endmodule

`default_nettype wire

// ==== testbench/host_mem_model.sv ====
/* Host memory model. Data for a line is its address in the upper half and the inverted
   address in the lower half. Completions leave one per cycle at most, in random order */
`default_nettype none

module host_mem_model
(
    input  wire logic                                    afu_clk,
    input  wire logic                                    reset,

    // Request packets from the DUT
    input  wire logic                                    req_valid,
    input  wire logic [host_rd_pkg::ADDR_WIDTH-1:0]      req_address,
    input  wire logic [3:0]                              req_len,
    input  wire logic [host_rd_pkg::ROB_IDX_WIDTH-1:0]   req_tag,

    // Completions back to the DUT, driven on the falling edge
    output logic                                         cpl_valid,
    output logic [host_rd_pkg::ROB_IDX_WIDTH-1:0]        cpl_tag,
    output logic [host_rd_pkg::DATA_WIDTH-1:0]           cpl_data
);

    // Fixed seed, so every run shuffles the same way
    integer seed = 32'h4fe2_68da;

    // Lines requested but not yet completed
    logic [host_rd_pkg::ROB_IDX_WIDTH-1:0] pend_tag [$];
    logic [host_rd_pkg::ADDR_WIDTH-1:0]    pend_addr [$];

    initial
    begin
        cpl_valid = 1'b0;
        cpl_tag   = '0;
        cpl_data  = '0;
    end

    always @(negedge afu_clk)
    begin : serve
        int k;
        int pick;
        if (reset)
        begin
            cpl_valid <= 1'b0;
            pend_tag.delete();
            pend_addr.delete();
        end
        else
        begin
            // Line k of a packet carries the packet tag plus k, wrapping with the ROB
            if (req_valid)
            begin
                for (k = 0; k < int'(req_len); k++)
                begin
                    pend_tag.push_back(req_tag + host_rd_pkg::ROB_IDX_WIDTH'(k));
                    pend_addr.push_back(req_address + host_rd_pkg::ADDR_WIDTH'(k));
                end
            end
            cpl_valid <= 1'b0;
            // Idle one cycle in four, then pick any pending line
            if ((pend_addr.size() != 0) && (($random(seed) & 3) != 0))
            begin
                pick = $unsigned($random(seed)) % pend_addr.size();
                cpl_valid <= 1'b1;
                cpl_tag   <= pend_tag[pick];
                cpl_data  <= {pend_addr[pick], ~pend_addr[pick]};
                pend_tag.delete(pick);
                pend_addr.delete(pick);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/host_rd_tb.sv ====
/* Testbench for the host read path. Bursts come from a table, and each returned line
   is matched against a queue of expected addresses in request order */
`default_nettype none

module host_rd_tb;

    localparam int MAX_PKT_LINES   = 4;
    localparam int PAGE_LINES      = 512;
    localparam int N_TESTS         = 8;
    localparam int ACCEPT_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT   = 2000;

    logic                                         afu_clk = 1'b0;
    logic                                         reset;
    logic                                         rd_read;
    logic [host_rd_pkg::ADDR_WIDTH-1:0]           rd_address;
    logic [host_rd_pkg::BURST_CNT_WIDTH-1:0]      rd_burstcount;
    logic                                         rd_waitrequest;
    logic [host_rd_pkg::DATA_WIDTH-1:0]           rd_readdata;
    logic                                         rd_readdatavalid;
    logic                                         req_valid;
    logic [host_rd_pkg::ADDR_WIDTH-1:0]           req_address;
    host_rd_pkg::pkt_len_t                        req_len;
    host_rd_pkg::rob_tag_t                        req_tag;
    logic                                         cpl_valid;
    logic [host_rd_pkg::ROB_IDX_WIDTH-1:0]        cpl_tag;
    logic [host_rd_pkg::DATA_WIDTH-1:0]           cpl_data;

    // Stimulus table, one row per burst
    string                              tname  [N_TESTS];
    logic [host_rd_pkg::ADDR_WIDTH-1:0] taddr  [N_TESTS];
    int                                 tcount [N_TESTS];
    bit                                 tchain [N_TESTS];

    // Expected lines in return order, with the test each belongs to
    logic [host_rd_pkg::ADDR_WIDTH-1:0] exp_addr [$];
    string                              exp_name [$];

    string cur_name = "reset";
    int    errors = 0;
    int    checks = 0;
    int    total_lines = 0;
    int    returned_lines = 0;
    int    lines_requested = 0;

    always #4 afu_clk = ~afu_clk;

    host_rd_top #(.MAX_PKT_LINES(MAX_PKT_LINES), .PAGE_LINES(PAGE_LINES)) u_dut
    (
        .afu_clk, .reset,
        .rd_read, .rd_address, .rd_burstcount, .rd_waitrequest,
        .rd_readdata, .rd_readdatavalid,
        .req_valid, .req_address, .req_len, .req_tag,
        .cpl_valid, .cpl_tag, .cpl_data
    );

    host_mem_model u_host
    (
        .afu_clk, .reset,
        .req_valid, .req_address, .req_len, .req_tag (req_tag.idx),
        .cpl_valid, .cpl_tag, .cpl_data
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_stimulus(input int i, input string name,
                                input logic [31:0] addr, input int count, input bit chain);
        tname[i]  = name;
        taddr[i]  = addr;
        tcount[i] = count;
        tchain[i] = chain;
    endtask

    // ====================
    // Monitors
    // ====================

    // Every packet stays under the length limit, inside one page, and tags run on
    always @(negedge afu_clk)
    begin
        if (!reset && req_valid)
        begin
            check_value({cur_name, "/pkt_len"}, 1,
                        (req_len != 0) && (int'(req_len) <= MAX_PKT_LINES));
            check_value({cur_name, "/pkt_page"}, 1,
                        (int'(req_address % PAGE_LINES) + int'(req_len)) <= PAGE_LINES);
            check_value({cur_name, "/pkt_tag"}, lines_requested % host_rd_pkg::ROB_LINES,
                        req_tag.idx);
            lines_requested += int'(req_len);
        end
    end

    // Returned lines must match the oldest outstanding address
    always @(negedge afu_clk)
    begin
        if (!reset && rd_readdatavalid)
        begin
            returned_lines++;
            if (exp_addr.size() == 0)
            begin
                $display("A line came back with no read outstanding, data %h", rd_readdata);
                errors++;
            end
            else
            begin
                check_value(exp_name[0], {exp_addr[0], ~exp_addr[0]}, rd_readdata);
                void'(exp_addr.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    // Called on a falling edge, returns on a falling edge
    task automatic issue_burst(input int i);
        int cycles;
        int k;
        cycles = 0;
        cur_name = tname[i];
        rd_read = 1'b1;
        rd_address = taddr[i];
        rd_burstcount = host_rd_pkg::BURST_CNT_WIDTH'(tcount[i]);
        // A chained burst arrives while the previous one is still being cut
        if (tchain[i])
            check_value({tname[i], "/held"}, 1, rd_waitrequest);
        while (rd_waitrequest && (cycles < ACCEPT_TIMEOUT))
        begin
            @(negedge afu_clk);
            cycles++;
        end
        if (rd_waitrequest)
        begin
            $display("Timeout: burst %s was never accepted", tname[i]);
            errors++;
            rd_read = 1'b0;
        end
        else
        begin
            for (k = 0; k < tcount[i]; k++)
            begin
                exp_addr.push_back(taddr[i] + 32'(k));
                exp_name.push_back(tname[i]);
            end
            total_lines += tcount[i];
            @(posedge afu_clk);
            @(negedge afu_clk);
            rd_read = 1'b0;
        end
    endtask

    task automatic wait_drained(input string name);
        int cycles;
        cycles = 0;
        while ((exp_addr.size() != 0) && (cycles < DRAIN_TIMEOUT))
        begin
            @(negedge afu_clk);
            cycles++;
        end
        if (exp_addr.size() != 0)
        begin
            $display("Timeout: %0d lines of %s never came back", exp_addr.size(), name);
            errors++;
        end
    endtask

    initial
    begin
        reset = 1'b1;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;

        add_stimulus(0, "single_line",   32'h0000_1000,  1, 1'b0);
        add_stimulus(1, "in_page_13",    32'h0000_2040, 13, 1'b0);
        // Three lines short of the page end at 0x3200
        add_stimulus(2, "page_cross_10", 32'h0000_31fd, 10, 1'b0);
        // 48 lines back to back, three times the ROB
        add_stimulus(3, "over_rob_a",    32'h0000_4000, 16, 1'b0);
        add_stimulus(4, "over_rob_b",    32'h0000_4010, 16, 1'b1);
        add_stimulus(5, "over_rob_c",    32'h0000_4020, 16, 1'b1);
        add_stimulus(6, "held_first",    32'h0000_5100,  6, 1'b0);
        add_stimulus(7, "held_second",   32'h0000_6200,  5, 1'b1);

        repeat (16) @(negedge afu_clk);
        reset = 1'b0;
        @(negedge afu_clk);

        for (int i = 0; i < N_TESTS; i++)
        begin
            issue_burst(i);
            // Drain only when the next row does not chain onto this one
            if ((i == N_TESTS - 1) || !tchain[i + 1])
                wait_drained(tname[i]);
        end

        // Idle window to catch any stray extra line
        cur_name = "end_of_run";
        repeat (20) @(negedge afu_clk);
        check_value("line_count", total_lines, returned_lines);

        $display("Checks: %0d, errors: %0d, lines: %0d", checks, errors, returned_lines);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
